//--- Makefile
# Verilator build for the lookahead FIFO

VERILATOR  ?= verilator
TOP        := lookaheadFifoTb
RTL_TOP    := lookaheadFifo
FILELIST   := lookaheadFifo.f
BUILD_DIR  := obj_dir
LINT_FLAGS := --lint-only --timing --assert
SIM_FLAGS  := --binary --timing --assert
PASS_TEXT  := No errors

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o $(TOP)
	@out="$$(./$(BUILD_DIR)/$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)

//--- include/fifo_macros.svh
`ifndef FIFO_MACROS_SVH
`define FIFO_MACROS_SVH

// Width of one stored data word
`define FIFO_WIDTH 16

// Address width of the block RAM
// One of the 32 entries always stays empty so 31 words fit
`define FIFO_DEPTH_LOG2 5

// Cycles from read issue to the data-valid strobe
`define FIFO_READ_LATENCY 4

// Almost full once fewer than this many entries are free
`define FIFO_ALMOST_FULL_MARGIN 8

// Almost empty while this many words or fewer are stored
`define FIFO_ALMOST_EMPTY_MARGIN 4

`endif

//--- lookaheadFifo.f
+incdir+include
source/fifoPkg.sv
source/fifoMemIf.sv
source/fifoReadIf.sv
source/fifoPointers.sv
source/fifoMemory.sv
source/lookaheadReg.sv
source/lookaheadFifo.sv
sim/lookaheadFifoTb.sv

//--- sim/lookaheadFifoTb.sv
`default_nettype none

`include "fifo_macros.svh"

module lookaheadFifoTb import fifoPkg::*; ();

    localparam int capacity     = (1 << `FIFO_DEPTH_LOG2) - 1;
    localparam int settleCycles = 8;

    logic      rdclk;
    logic      rst;
    logic      writeEnable;
    dataWord_t dataIn;
    logic      almostFull;
    logic      almostEmpty;
    logic      grab;
    logic      dataAvailable;
    dataWord_t dataOut;

    // Words written and not yet grabbed with the oldest at the front
    dataWord_t scoreboard [$];
    dataWord_t headWord     = '0;
    int        writtenCount = 0;
    int        grabbedCount = 0;
    int        idleCycles   = 0;

    logic [31:0] lcgState = 32'haa9ebc10;

    // Model view of the core
    int   coreCount;
    logic steady;
    logic expAlmostFull;
    logic expAlmostEmpty;
    logic expAvailable;

    // Lookahead word is no longer in the core
    assign coreCount      = writtenCount - grabbedCount - (dataAvailable ? 1 : 0);
    assign steady         = idleCycles >= settleCycles;
    assign expAlmostFull  = (capacity - coreCount) < `FIFO_ALMOST_FULL_MARGIN;
    assign expAlmostEmpty = coreCount <= `FIFO_ALMOST_EMPTY_MARGIN;
    assign expAvailable   = writtenCount != grabbedCount;

    lookaheadFifo lookaheadFifo_i (
        .rdclk         (rdclk),
        .rst           (rst),
        .writeEnable   (writeEnable),
        .dataIn        (dataIn),
        .almostFull    (almostFull),
        .almostEmpty   (almostEmpty),
        .grab          (grab),
        .dataAvailable (dataAvailable),
        .dataOut       (dataOut)
    );

    initial begin
        rdclk = 1'b0;
        forever #20 rdclk = ~rdclk;
    end

    task automatic failValue(input string name, input logic [31:0] got,
                             input logic [31:0] expected);
        $display("CHECK FAILED %s got %h expected %h", name, got, expected);
        $display("Errors found");
        $fatal(1);
    endtask

    task automatic failPlain(input string what);
        $display("%s", what);
        $display("Errors found");
        $fatal(1);
    endtask

    function automatic logic [31:0] lcgNext();
        lcgState = lcgState * 32'd1664525 + 32'd1013904223;
        return lcgState;
    endfunction

    // One clock of stimulus applied shortly after the rising edge
    task automatic driveCycle(input logic wantWrite, input logic obeyFull,
                              input logic wantGrab);
        logic [31:0] randWord;
        logic        doWrite;
        logic        doGrab;
        @(posedge rdclk);
        #2;
        doWrite     = wantWrite && !(obeyFull && almostFull);
        doGrab      = wantGrab && dataAvailable;
        writeEnable = doWrite;
        grab        = doGrab;
        if (doWrite) begin
            randWord = lcgNext();
            dataIn   = randWord[31:16];
            scoreboard.push_back(dataIn);
            writtenCount++;
        end
        if (doGrab && scoreboard.size() == 0) begin
            failPlain("dataAvailable is high although every written word was grabbed");
        end else if (doGrab) begin
            headWord = scoreboard.pop_front();
            grabbedCount++;
        end else if (scoreboard.size() > 0) begin
            headWord = scoreboard[0];
        end
        if (doWrite || doGrab) begin
            idleCycles = 0;
        end else begin
            idleCycles++;
        end
    endtask

    task automatic idleFor(input int cycles);
        repeat (cycles) driveCycle(1'b0, 1'b0, 1'b0);
    endtask

    task automatic waitForDataAvailable(input int limit);
        int waited;
        waited = 0;
        while (!dataAvailable) begin
            if (waited == limit) begin
                failPlain("dataAvailable did not rise after a word was written");
            end else begin
                driveCycle(1'b0, 1'b0, 1'b0);
                waited++;
            end
        end
    endtask

    // Grab whenever a word is offered until everything is out
    task automatic drainAll(input int limit);
        int waited;
        waited = 0;
        while (grabbedCount != writtenCount) begin
            if (waited == limit) begin
                failPlain("FIFO did not drain before the timeout");
            end else begin
                driveCycle(1'b0, 1'b0, 1'b1);
                waited++;
            end
        end
    endtask

    // Flags while reset is held
    resetFlags: assert property (@(posedge rdclk)
        rst && $past(rst) |-> !dataAvailable && !almostFull && almostEmpty)
        else failValue("{dataAvailable,almostFull,almostEmpty}",
                       32'({$sampled(dataAvailable), $sampled(almostFull),
                            $sampled(almostEmpty)}), 32'h1);

    // Offered word is always the oldest one not yet grabbed
    headData: assert property (@(posedge rdclk) disable iff (rst)
        dataAvailable |-> dataOut == headWord)
        else failValue("dataOut", 32'($sampled(dataOut)), 32'($sampled(headWord)));

    holdAvailable: assert property (@(posedge rdclk) disable iff (rst)
        dataAvailable && !grab |=> dataAvailable)
        else failPlain("dataAvailable dropped while its word was not grabbed");

    steadyAlmostFull: assert property (@(posedge rdclk) disable iff (rst)
        steady |-> almostFull == expAlmostFull)
        else failValue("almostFull", 32'($sampled(almostFull)),
                       32'($sampled(expAlmostFull)));

    steadyAlmostEmpty: assert property (@(posedge rdclk) disable iff (rst)
        steady |-> almostEmpty == expAlmostEmpty)
        else failValue("almostEmpty", 32'($sampled(almostEmpty)),
                       32'($sampled(expAlmostEmpty)));

    // Once settled, lookahead holds a word exactly when one is stored
    steadyAvailable: assert property (@(posedge rdclk) disable iff (rst)
        steady |-> dataAvailable == expAvailable)
        else failValue("dataAvailable", 32'($sampled(dataAvailable)),
                       32'($sampled(expAvailable)));

    initial begin
        logic [31:0] r;
        logic [2:0]  rate;
        rst         = 1'b1;
        writeEnable = 1'b0;
        grab        = 1'b0;
        dataIn      = '0;
        repeat (3) @(posedge rdclk);
        #2;
        rst = 1'b0;

        // Fill one word at a time up to the full core plus the lookahead word
        for (int k = 1; k <= capacity + 1; k++) begin
            driveCycle(1'b1, 1'b0, 1'b0);
            waitForDataAvailable(20);
            idleFor(settleCycles + 2);
        end

        drainAll((capacity + 1) * 8 + 40);
        idleFor(settleCycles + 2);

        // Random traffic that first fills and then mostly drains
        for (int round = 0; round < 2; round++) begin
            rate = (round == 0) ? 3'd5 : 3'd1;
            for (int c = 0; c < 400; c++) begin
                r = lcgNext();
                driveCycle(r[23:21] < rate, 1'b1, r[27]);
                if (c % 50 == 49) begin
                    idleFor(settleCycles + 2);
                end
            end
        end

        drainAll(scoreboard.size() * 8 + 40);
        idleFor(settleCycles + 2);

        $display("No errors");
        $finish;
    end

endmodule

`default_nettype wire

//--- source/fifoMemIf.sv
`default_nettype none

interface fifoMemIf import fifoPkg::*; ();

    // Write port
    logic      writeEnable;
    fifoAddr_t writeAddr;
    dataWord_t dataIn;

    // Read port with a one-cycle enable pulse and its address
    logic      readEnable;
    fifoAddr_t readAddr;
    dataWord_t readData;

    modport controller (
        output writeEnable, writeAddr, dataIn,
        output readEnable, readAddr,
        input  readData
    );

    modport memory (
        input  writeEnable, writeAddr, dataIn,
        input  readEnable, readAddr,
        output readData
    );

endinterface

`default_nettype wire

//--- source/fifoMemory.sv
`default_nettype none

`include "fifo_macros.svh"

module fifoMemory import fifoPkg::*; (
    input logic rdclk,

    fifoMemIf.memory mem
);

    dataWord_t ram [0:(1 << `FIFO_DEPTH_LOG2)-1];

    // Read request delayed one cycle so the address is settled
    logic      readEnD;
    fifoAddr_t readAddrD;

    // RAM read register and its enable
    dataWord_t ramWord;
    logic      ramEn;

    // Two output stages
    dataWord_t outStage1;
    logic      outEn;
    dataWord_t outStage2;

    always_ff @(posedge rdclk) begin
        if (mem.writeEnable) begin
            ram[mem.writeAddr] <= mem.dataIn;
        end
    end

    always_ff @(posedge rdclk) begin
        readEnD   <= mem.readEnable;
        readAddrD <= mem.readAddr;
        ramEn     <= readEnD;
        outEn     <= ramEn;
    end

    // Stages only load on a read and otherwise keep the last word
    always_ff @(posedge rdclk) begin
        if (readEnD) begin
            ramWord <= ram[readAddrD];
        end
        if (ramEn) begin
            outStage1 <= ramWord;
        end
        if (outEn) begin
            outStage2 <= outStage1;
        end
    end

    assign mem.readData = outStage2;

    // Read slot is never the one the write head is filling
    assert property (@(posedge rdclk)
        readEnD |-> !(mem.writeEnable && mem.writeAddr == readAddrD));

endmodule

`default_nettype wire

//--- source/fifoPkg.sv
`default_nettype none

`include "fifo_macros.svh"

package fifoPkg;

    // One data word as written and read
    typedef logic [`FIFO_WIDTH-1:0] dataWord_t;

    // RAM address and pointer type
    // Differences between pointers wrap modulo the depth
    typedef logic [`FIFO_DEPTH_LOG2-1:0] fifoAddr_t;

endpackage

`default_nettype wire

//--- source/fifoPointers.sv
`default_nettype none

`include "fifo_macros.svh"

module fifoPointers import fifoPkg::*; (
    input  logic      rdclk,
    input  logic      rst,

    // Write side
    input  logic      writeEnable,
    input  dataWord_t dataIn,
    output logic      almostFull,
    output logic      almostEmpty,

    fifoMemIf.controller  mem,
    fifoReadIf.controller rd
);

    fifoAddr_t writeAddr;
    fifoAddr_t readAddr;

    // Words stored and entries still free
    fifoAddr_t usedWords;
    fifoAddr_t writesLeft;

    logic isReading;

    // Read strobe travelling alongside the RAM pipeline
    logic [`FIFO_READ_LATENCY-1:0] validPipe;

    // Read pointer sits on the last consumed slot just behind the head word
    assign usedWords  = writeAddr - readAddr - fifoAddr_t'(1);
    assign writesLeft = readAddr - writeAddr;

    assign rd.fifoEmpty = usedWords == '0;
    assign almostEmpty  = usedWords <= fifoAddr_t'(`FIFO_ALMOST_EMPTY_MARGIN);

    // Requests on an empty FIFO are dropped
    assign isReading = rd.readRequest && !rd.fifoEmpty;

    assign mem.writeEnable = writeEnable;
    assign mem.writeAddr   = writeAddr;
    assign mem.dataIn      = dataIn;

    // Head word lives one past the read pointer
    assign mem.readEnable = isReading;
    assign mem.readAddr   = readAddr + fifoAddr_t'(1);

    assign rd.readData  = mem.readData;
    assign rd.readValid = validPipe[`FIFO_READ_LATENCY-1];

    always_ff @(posedge rdclk) begin
        if (rst) begin
            // Write head starts one ahead, so capacity is depth minus one
            writeAddr  <= fifoAddr_t'(1);
            readAddr   <= '0;
            almostFull <= 1'b0;
            validPipe  <= '0;
        end else begin
            if (writeEnable) begin
                writeAddr <= writeAddr + fifoAddr_t'(1);
            end
            if (isReading) begin
                readAddr <= readAddr + fifoAddr_t'(1);
            end
            almostFull <= writesLeft < fifoAddr_t'(`FIFO_ALMOST_FULL_MARGIN);
            validPipe  <= {validPipe[`FIFO_READ_LATENCY-2:0], isReading};
        end
    end

    // Writer honours the capacity
    assert property (@(posedge rdclk) disable iff (rst)
        writeEnable |-> writesLeft != '0);

    // Reader only asks for a word while one is stored
    assert property (@(posedge rdclk) disable iff (rst)
        rd.readRequest |-> !rd.fifoEmpty);

endmodule

`default_nettype wire

//--- source/fifoReadIf.sv
`default_nettype none

interface fifoReadIf import fifoPkg::*; ();

    logic      fifoEmpty;
    logic      readRequest;

    // Word arrives a fixed latency after the request
    dataWord_t readData;
    logic      readValid;

    modport controller (
        output fifoEmpty,
        output readData,
        output readValid,
        input  readRequest
    );

    modport register (
        input  fifoEmpty,
        input  readData,
        input  readValid,
        output readRequest
    );

endinterface

`default_nettype wire

//--- source/lookaheadFifo.sv
`default_nettype none

module lookaheadFifo import fifoPkg::*; (
    input  logic      rdclk,
    input  logic      rst,

    // Write side
    input  logic      writeEnable,
    input  dataWord_t dataIn,
    output logic      almostFull,
    output logic      almostEmpty,

    // Read side
    input  logic      grab,
    output logic      dataAvailable,
    output dataWord_t dataOut
);

    // Pointer logic to RAM
    fifoMemIf memBus ();

    // FIFO read side to output register
    fifoReadIf readBus ();

    fifoPointers pointers (
        .rdclk       (rdclk),
        .rst         (rst),
        .writeEnable (writeEnable),
        .dataIn      (dataIn),
        .almostFull  (almostFull),
        .almostEmpty (almostEmpty),
        .mem         (memBus.controller),
        .rd          (readBus.controller)
    );

    fifoMemory memory (
        .rdclk (rdclk),
        .mem   (memBus.memory)
    );

    // Zero-latency view of the head word
    lookaheadReg outReg (
        .rdclk         (rdclk),
        .rst           (rst),
        .rd            (readBus.register),
        .grab          (grab),
        .dataAvailable (dataAvailable),
        .dataOut       (dataOut)
    );

endmodule

`default_nettype wire

//--- source/lookaheadReg.sv
`default_nettype none

module lookaheadReg import fifoPkg::*; (
    input  logic      rdclk,
    input  logic      rst,

    // FIFO read side
    fifoReadIf.register rd,

    // Consumer side
    input  logic      grab,
    output logic      dataAvailable,
    output dataWord_t dataOut
);

    // A read has been issued and its word has not arrived yet
    logic inFlight;

    // Refill on grab, or prefetch when idle.
    // The in-flight check stops a second read from overwriting the first
    // when the FIFO briefly empties during the read latency.
    assign rd.readRequest = !rd.fifoEmpty && (grab || (!dataAvailable && !inFlight));

    always_ff @(posedge rdclk) begin
        if (rst) begin
            dataAvailable <= 1'b0;
            inFlight      <= 1'b0;
        end else begin
            if (grab) begin
                dataAvailable <= 1'b0;
            end else if (rd.readValid) begin
                dataAvailable <= 1'b1;
                inFlight      <= 1'b0;
            end
            // Never coincides with an arriving word
            if (rd.readRequest) begin
                inFlight <= 1'b1;
            end
        end
    end

    // Held word
    always_ff @(posedge rdclk) begin
        if (rd.readValid) begin
            dataOut <= rd.readData;
        end
    end

    // Data only shows up for a read this register asked for
    assert property (@(posedge rdclk) disable iff (rst)
        rd.readValid |-> inFlight);

    // Consumer only takes a word that is there
    assert property (@(posedge rdclk) disable iff (rst)
        grab |-> dataAvailable);

endmodule

`default_nettype wire
